// File: rot_matrix_builder.sv
`default_nettype none
`timescale 1ns/10ps

module rot_matrix_builder (
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire xform_pkg::axis_trig_t    trig,
    input  wire xform_pkg::xform_side_t   side,
    input  wire logic                     in_valid,
    output logic                          in_ready,

    output xform_pkg::rot_mtx_t           mtx,
    output xform_pkg::xform_side_t        side_out,
    output logic                          out_valid,
    input  wire logic                     out_ready,

    output logic                          busy
);
    import xform_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_output
    } state_t;

    state_t state;

    axis_trig_t trig_r;

    // Shared partial products
    q16_16_t cz_cy, sz_cy, cy_sx, cy_cx;
    q16_16_t cz_sy, sz_sy;
    q16_16_t sz_sx, sz_cx, cz_sx, cz_cx;

    rot_mtx_t mtx_next;

    always_comb begin
        cz_cy = mul_q16(trig_r.cos_z, trig_r.cos_y);
        sz_cy = mul_q16(trig_r.sin_z, trig_r.cos_y);
        cy_sx = mul_q16(trig_r.cos_y, trig_r.sin_x);
        cy_cx = mul_q16(trig_r.cos_y, trig_r.cos_x);
        cz_sy = mul_q16(trig_r.cos_z, trig_r.sin_y);
        sz_sy = mul_q16(trig_r.sin_z, trig_r.sin_y);
        sz_sx = mul_q16(trig_r.sin_z, trig_r.sin_x);
        sz_cx = mul_q16(trig_r.sin_z, trig_r.cos_x);
        cz_sx = mul_q16(trig_r.cos_z, trig_r.sin_x);
        cz_cx = mul_q16(trig_r.cos_z, trig_r.cos_x);

        mtx_next.r11 = cz_cy;
        mtx_next.r12 = mul_q16(cz_sy, trig_r.sin_x) - sz_cx;
        mtx_next.r13 = mul_q16(cz_sy, trig_r.cos_x) + sz_sx;
        mtx_next.r21 = sz_cy;
        mtx_next.r22 = mul_q16(sz_sy, trig_r.sin_x) + cz_cx;
        mtx_next.r23 = mul_q16(sz_sy, trig_r.cos_x) - cz_sx;
        mtx_next.r31 = -trig_r.sin_y;
        mtx_next.r32 = cy_sx;
        mtx_next.r33 = cy_cx;
    end

    assign in_ready = (state == st_idle);
    assign busy     = (state != st_idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            out_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        state <= st_compute;
                    end
                end
                st_compute: begin
                    state <= st_output;
                end
                st_output: begin
                    // Valid rises one edge after the matrix lands
                    out_valid <= 1'b1;
                    if (out_valid && out_ready) begin
                        out_valid <= 1'b0;
                        state     <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && in_valid) begin
            trig_r   <= trig;
            side_out <= side;
        end
        if (state == st_compute) begin
            mtx <= mtx_next;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module transform_setup_tb -f verilog.f -o transform_setup_sim

sim_out=$(./obj_dir/transform_setup_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// File: tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    initial clk = 1'b0;

    always #2 clk = ~clk;

    // Four rising edges in reset, released between edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: transform_setup.sv
`default_nettype none
`timescale 1ns/10ps

module transform_setup (
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire xform_pkg::xform_setup_t  setup,
    input  wire logic                     in_valid,
    output logic                          in_ready,

    output xform_pkg::view_xform_t        result,
    output logic                          out_valid,
    input  wire logic                     out_ready,

    output logic                          busy
);
    import xform_pkg::*;

    xform_side_t model_side_in;
    xform_side_t model_side;
    rot_mtx_t    model_mtx;
    rot_mtx_t    camera_mtx;

    logic model_in_ready, camera_in_ready;
    logic model_valid, camera_valid;
    logic model_ready, camera_ready;
    logic model_busy, camera_busy, comb_busy;

    // Both builders take a request on the same edge or not at all
    assign in_ready = model_in_ready && camera_in_ready;
    assign busy     = model_busy || camera_busy || comb_busy;

    assign model_side_in = '{tag: setup.tag, pos: setup.model_pos, scale: setup.model_scale};

    rot_matrix_builder u_model_builder (
        .clk       (clk),
        .rst       (rst),
        .trig      (setup.model_trig),
        .side      (model_side_in),
        .in_valid  (in_valid && camera_in_ready),
        .in_ready  (model_in_ready),
        .mtx       (model_mtx),
        .side_out  (model_side),
        .out_valid (model_valid),
        .out_ready (model_ready),
        .busy      (model_busy)
    );

    rot_matrix_builder u_camera_builder (
        .clk       (clk),
        .rst       (rst),
        .trig      (setup.camera_trig),
        .side      ('0),
        .in_valid  (in_valid && model_in_ready),
        .in_ready  (camera_in_ready),
        .mtx       (camera_mtx),
        .side_out  (),
        .out_valid (camera_valid),
        .out_ready (camera_ready),
        .busy      (camera_busy)
    );

    view_combiner u_combiner (
        .clk          (clk),
        .rst          (rst),
        .model_mtx    (model_mtx),
        .model_side   (model_side),
        .model_valid  (model_valid),
        .model_ready  (model_ready),
        .camera_mtx   (camera_mtx),
        .camera_valid (camera_valid),
        .camera_ready (camera_ready),
        .result       (result),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (comb_busy)
    );

endmodule

`default_nettype wire

// File: transform_setup_checker.sv
`default_nettype none
`timescale 1ns/10ps

`include "xform_params.svh"

module transform_setup_checker (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire xform_pkg::xform_setup_t setup,
    input  wire logic                    in_valid,
    input  wire logic                    in_ready,
    input  wire xform_pkg::view_xform_t  result,
    input  wire logic                    out_valid,
    input  wire logic                    out_ready,
    input  wire logic                    busy,
    output int                           mismatches,
    output int                           errors,
    output int                           accepted,
    output int                           delivered
);
    import xform_pkg::*;

    view_xform_t exp_q[$];
    view_xform_t held;
    view_xform_t want;
    logic        hold_pending = 1'b0;
    logic        lat_armed = 1'b0;
    int          lat_cnt = 0;
    int          mismatch_cnt = 0;
    int          error_cnt = 0;
    int          accepted_cnt = 0;
    int          delivered_cnt = 0;

    assign mismatches = mismatch_cnt;
    assign errors     = error_cnt;
    assign accepted   = accepted_cnt;
    assign delivered  = delivered_cnt;

    // Q16.16 product as full 64-bit result shifted right by the fraction bits
    function automatic q16_16_t fixed_mul(input q16_16_t a, input q16_16_t b);
        longint full;
        full = longint'(a) * longint'(b);
        return q16_16_t'(full >>> `XFORM_FRAC_BITS);
    endfunction

    function automatic q16_16_t dot3(input q16_16_t a1, input q16_16_t a2, input q16_16_t a3,
                                     input q16_16_t b1, input q16_16_t b2, input q16_16_t b3);
        return fixed_mul(a1, b1) + fixed_mul(a2, b2) + fixed_mul(a3, b3);
    endfunction

    function automatic rot_mtx_t rotation(input axis_trig_t t);
        rot_mtx_t m;
        q16_16_t  czsy;
        q16_16_t  szsy;
        czsy  = fixed_mul(t.cos_z, t.sin_y);
        szsy  = fixed_mul(t.sin_z, t.sin_y);
        m.r11 = fixed_mul(t.cos_z, t.cos_y);
        m.r12 = fixed_mul(czsy, t.sin_x) - fixed_mul(t.sin_z, t.cos_x);
        m.r13 = fixed_mul(czsy, t.cos_x) + fixed_mul(t.sin_z, t.sin_x);
        m.r21 = fixed_mul(t.sin_z, t.cos_y);
        m.r22 = fixed_mul(szsy, t.sin_x) + fixed_mul(t.cos_z, t.cos_x);
        m.r23 = fixed_mul(szsy, t.cos_x) - fixed_mul(t.cos_z, t.sin_x);
        m.r31 = -t.sin_y;
        m.r32 = fixed_mul(t.cos_y, t.sin_x);
        m.r33 = fixed_mul(t.cos_y, t.cos_x);
        return m;
    endfunction

    // Camera times model, plus the pass-along fields
    function automatic view_xform_t expected_result(input xform_setup_t req);
        view_xform_t e;
        rot_mtx_t    m;
        rot_mtx_t    c;
        m = rotation(req.model_trig);
        c = rotation(req.camera_trig);
        e.tag         = req.tag;
        e.model_pos   = req.model_pos;
        e.model_scale = req.model_scale;
        e.mv_mtx.r11  = dot3(c.r11, c.r12, c.r13, m.r11, m.r21, m.r31);
        e.mv_mtx.r12  = dot3(c.r11, c.r12, c.r13, m.r12, m.r22, m.r32);
        e.mv_mtx.r13  = dot3(c.r11, c.r12, c.r13, m.r13, m.r23, m.r33);
        e.mv_mtx.r21  = dot3(c.r21, c.r22, c.r23, m.r11, m.r21, m.r31);
        e.mv_mtx.r22  = dot3(c.r21, c.r22, c.r23, m.r12, m.r22, m.r32);
        e.mv_mtx.r23  = dot3(c.r21, c.r22, c.r23, m.r13, m.r23, m.r33);
        e.mv_mtx.r31  = dot3(c.r31, c.r32, c.r33, m.r11, m.r21, m.r31);
        e.mv_mtx.r32  = dot3(c.r31, c.r32, c.r33, m.r12, m.r22, m.r32);
        e.mv_mtx.r33  = dot3(c.r31, c.r32, c.r33, m.r13, m.r23, m.r33);
        return e;
    endfunction

    task automatic report_mismatch(input string name, input string exp_s, input string act_s);
        mismatch_cnt++;
        $display("Mismatch %s expected %s actual %s", name, exp_s, act_s);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            // out_valid sampled here was set by the previous edge
            if (lat_armed) begin
                lat_cnt++;
                if (out_valid) begin
                    lat_armed = 1'b0;
                    if (lat_cnt - 1 != 6) begin
                        report_mismatch("latency", "6", $sformatf("%0d", lat_cnt - 1));
                    end
                end else if (lat_cnt > 40) begin
                    lat_armed = 1'b0;
                    error_cnt++;
                    $display("out_valid never rose after a request to the idle DUT");
                end
            end
            if (in_valid && in_ready) begin
                if (!busy) begin
                    lat_armed = 1'b1;
                    lat_cnt   = 0;
                end
                exp_q.push_back(expected_result(setup));
                accepted_cnt++;
            end
            if (hold_pending) begin
                if (!out_valid) begin
                    error_cnt++;
                    $display("out_valid dropped before the result was taken");
                end else if (result !== held) begin
                    report_mismatch("stable_hold", $sformatf("%h", held),
                                    $sformatf("%h", result));
                end
            end
            hold_pending = out_valid && !out_ready;
            held = result;
            if (out_valid && out_ready) begin
                delivered_cnt++;
                if (exp_q.size() == 0) begin
                    error_cnt++;
                    $display("Output transfer with no accepted request pending");
                end else begin
                    want = exp_q.pop_front();
                    if (result.tag !== want.tag)
                        report_mismatch("result_tag", $sformatf("%h", want.tag),
                                        $sformatf("%h", result.tag));
                    if (result.mv_mtx !== want.mv_mtx)
                        report_mismatch("result_mv_mtx", $sformatf("%h", want.mv_mtx),
                                        $sformatf("%h", result.mv_mtx));
                    if (result.model_pos !== want.model_pos)
                        report_mismatch("result_model_pos", $sformatf("%h", want.model_pos),
                                        $sformatf("%h", result.model_pos));
                    if (result.model_scale !== want.model_scale)
                        report_mismatch("result_model_scale",
                                        $sformatf("%h", want.model_scale),
                                        $sformatf("%h", result.model_scale));
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: transform_setup_sva.sv
`default_nettype none
`timescale 1ns/10ps

module transform_setup_sva (
    input wire logic                   clk,
    input wire logic                   rst,
    input wire logic                   in_ready,
    input wire xform_pkg::view_xform_t result,
    input wire logic                   out_valid,
    input wire logic                   out_ready,
    input wire logic                   busy
);

    // Stalled output holds value and valid
    hold_until_taken: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(result))
        else $error("Stalled output changed or dropped before it was taken");

    reset_state: assert property (@(posedge clk)
        rst |-> !out_valid && in_ready && !busy)
        else $error("Ports are not in their reset state while reset is high");

endmodule

bind transform_setup transform_setup_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .result    (result),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .busy      (busy)
);

`default_nettype wire

// File: transform_setup_tb.sv
`default_nettype none
`timescale 1ns/10ps

module transform_setup_tb;
    import xform_pkg::*;

    localparam int      num_requests = 200;
    localparam int      wait_limit   = 200;
    localparam q16_16_t fix_one      = 32'sh0001_0000;

    logic         clk;
    logic         rst;
    xform_setup_t setup;
    logic         in_valid;
    logic         in_ready;
    view_xform_t  result;
    logic         out_valid;
    logic         out_ready;
    logic         busy;

    int         chk_mismatches;
    int         chk_errors;
    int         accepted;
    int         delivered;
    int         mismatches = 0;
    int         errors = 0;
    int         total;
    int         sent;
    int         cycles;
    logic       accept_next;
    logic       timed_out = 1'b0;
    xform_tag_t next_tag;

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    transform_setup u_transform_setup (
        .clk       (clk),
        .rst       (rst),
        .setup     (setup),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .result    (result),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (busy)
    );

    transform_setup_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .setup      (setup),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .result     (result),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .busy       (busy),
        .mismatches (chk_mismatches),
        .errors     (chk_errors),
        .accepted   (accepted),
        .delivered  (delivered)
    );

    // Uniform in [-1.0, 1.0]
    function automatic q16_16_t random_unit();
        int v;
        v = int'($urandom_range(131072)) - 65536;
        return q16_16_t'(v);
    endfunction

    function automatic axis_trig_t random_trig();
        return '{random_unit(), random_unit(), random_unit(),
                 random_unit(), random_unit(), random_unit()};
    endfunction

    function automatic xform_setup_t random_request(input xform_tag_t tag);
        xform_setup_t r;
        r.tag         = tag;
        r.model_trig  = random_trig();
        r.camera_trig = random_trig();
        r.model_pos   = '{q16_16_t'($urandom), q16_16_t'($urandom), q16_16_t'($urandom)};
        r.model_scale = q16_16_t'($urandom);
        return r;
    endfunction

    function automatic xform_setup_t identity_request(input xform_tag_t tag);
        xform_setup_t r;
        r             = '0;
        r.tag         = tag;
        r.model_trig  = '{32'sd0, fix_one, 32'sd0, fix_one, 32'sd0, fix_one};
        r.camera_trig = r.model_trig;
        r.model_pos   = '{fix_one, 2 * fix_one, 3 * fix_one};
        r.model_scale = fix_one;
        return r;
    endfunction

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch %s expected %0b actual %0b", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            mismatches++;
            $display("Mismatch %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic run_identity();
        rot_mtx_t ident;
        ident     = '0;
        ident.r11 = fix_one;
        ident.r22 = fix_one;
        ident.r33 = fix_one;
        out_ready = 1'b1;
        setup     = identity_request(next_tag);
        in_valid  = 1'b1;
        cycles    = 0;
        while (!in_ready && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!in_ready) begin
            errors++;
            timed_out = 1'b1;
            $display("Identity request was never accepted");
        end else begin
            // Taken on the edge just passed
            @(negedge clk);
            in_valid = 1'b0;
            next_tag++;
            sent   = 0;
            cycles = 0;
            while (!out_valid && cycles < wait_limit) begin
                @(negedge clk);
                cycles++;
            end
            if (!out_valid) begin
                errors++;
                timed_out = 1'b1;
                $display("No output arrived for the identity request");
            end else if (result.mv_mtx !== ident) begin
                mismatches++;
                $display("Mismatch identity expected %h actual %h", ident, result.mv_mtx);
            end
            @(negedge clk);
        end
    endtask

    task automatic run_random();
        int stall;
        stall       = 0;
        cycles      = 0;
        accept_next = 1'b0;
        while (sent < num_requests && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (in_valid && accept_next) begin
                in_valid = 1'b0;
                sent++;
                next_tag++;
                stall = 0;
            end
            out_ready = ($urandom_range(99) < 70);
            if (!in_valid && sent < num_requests && $urandom_range(99) < 70) begin
                setup    = random_request(next_tag);
                in_valid = 1'b1;
            end
            // in_ready is stable until the next rising edge
            accept_next = in_valid && in_ready;
            if (in_valid && !accept_next) stall++;
            if (stall > wait_limit || cycles > num_requests * 100) begin
                errors++;
                timed_out = 1'b1;
                $display("Random requests stopped being accepted");
            end
        end
    endtask

    task automatic drain();
        cycles = 0;
        while (delivered < accepted && cycles < wait_limit) begin
            @(negedge clk);
            out_ready = ($urandom_range(99) < 70);
            cycles++;
        end
        if (delivered < accepted) begin
            errors++;
            timed_out = 1'b1;
            $display("Outputs still missing when the drain wait ran out");
        end
        out_ready = 1'b1;
    endtask

    initial begin
        setup       = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        accept_next = 1'b0;
        next_tag    = '0;
        sent        = 0;
        void'($urandom(65));

        cycles = 0;
        @(posedge clk);
        while (rst && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (rst) begin
            errors++;
            timed_out = 1'b1;
            $display("Reset was never released");
        end else begin
            @(negedge clk);
            check_flag("reset_out_valid", 1'b0, out_valid);
            check_flag("reset_busy", 1'b0, busy);
            check_flag("reset_in_ready", 1'b1, in_ready);
            run_identity();
        end
        if (!timed_out) run_random();
        if (!timed_out) drain();
        if (!timed_out) begin
            check_count("request_count", num_requests + 1, accepted);
            check_count("output_count", accepted, delivered);
        end

        total = mismatches + chk_mismatches + errors + chk_errors;
        $display("Mismatches: %0d, other errors: %0d",
                 mismatches + chk_mismatches, errors + chk_errors);
        if (total == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
xform_pkg.sv
rot_matrix_builder.sv
view_combiner.sv
transform_setup.sv
tb_clock_gen.sv
transform_setup_sva.sv
transform_setup_checker.sv
transform_setup_tb.sv

// File: view_combiner.sv
`default_nettype none
`timescale 1ns/10ps

module view_combiner (
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire xform_pkg::rot_mtx_t      model_mtx,
    input  wire xform_pkg::xform_side_t   model_side,
    input  wire logic                     model_valid,
    output logic                          model_ready,

    input  wire xform_pkg::rot_mtx_t      camera_mtx,
    input  wire logic                     camera_valid,
    output logic                          camera_ready,

    output xform_pkg::view_xform_t        result,
    output logic                          out_valid,
    input  wire logic                     out_ready,

    output logic                          busy
);
    import xform_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_row1,
        st_row2,
        st_row3,
        st_output
    } state_t;

    state_t state;

    rot_mtx_t model_r;
    rot_mtx_t camera_r;

    logic join_go;

    // Camera row picked by the current state
    q16_16_t c1, c2, c3;
    q16_16_t p11, p12, p13;
    q16_16_t p21, p22, p23;
    q16_16_t p31, p32, p33;
    q16_16_t sum1, sum2, sum3;

    assign join_go      = (state == st_idle) && model_valid && camera_valid;
    assign model_ready  = join_go;
    assign camera_ready = join_go;
    assign busy         = (state != st_idle);

    always_comb begin
        case (state)
            st_row2: begin
                c1 = camera_r.r21;
                c2 = camera_r.r22;
                c3 = camera_r.r23;
            end
            st_row3: begin
                c1 = camera_r.r31;
                c2 = camera_r.r32;
                c3 = camera_r.r33;
            end
            default: begin
                c1 = camera_r.r11;
                c2 = camera_r.r12;
                c3 = camera_r.r13;
            end
        endcase

        // Same nine multipliers serve every row
        p11 = mul_q16(c1, model_r.r11);
        p12 = mul_q16(c1, model_r.r12);
        p13 = mul_q16(c1, model_r.r13);
        p21 = mul_q16(c2, model_r.r21);
        p22 = mul_q16(c2, model_r.r22);
        p23 = mul_q16(c2, model_r.r23);
        p31 = mul_q16(c3, model_r.r31);
        p32 = mul_q16(c3, model_r.r32);
        p33 = mul_q16(c3, model_r.r33);

        sum1 = p11 + p21 + p31;
        sum2 = p12 + p22 + p32;
        sum3 = p13 + p23 + p33;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            out_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (join_go) begin
                        state <= st_row1;
                    end
                end
                st_row1: state <= st_row2;
                st_row2: state <= st_row3;
                st_row3: begin
                    state     <= st_output;
                    out_valid <= 1'b1;
                end
                st_output: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        state     <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (join_go) begin
                    model_r            <= model_mtx;
                    camera_r           <= camera_mtx;
                    result.tag         <= model_side.tag;
                    result.model_pos   <= model_side.pos;
                    result.model_scale <= model_side.scale;
                end
            end
            st_row1: begin
                result.mv_mtx.r11 <= sum1;
                result.mv_mtx.r12 <= sum2;
                result.mv_mtx.r13 <= sum3;
            end
            st_row2: begin
                result.mv_mtx.r21 <= sum1;
                result.mv_mtx.r22 <= sum2;
                result.mv_mtx.r23 <= sum3;
            end
            st_row3: begin
                result.mv_mtx.r31 <= sum1;
                result.mv_mtx.r32 <= sum2;
                result.mv_mtx.r33 <= sum3;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: xform_params.svh
`ifndef XFORM_PARAMS_SVH
`define XFORM_PARAMS_SVH

// Q16.16 fixed point
`define XFORM_FIX_W      32
`define XFORM_FRAC_BITS  16

// Request tag
`define XFORM_TAG_W      8

`endif

// File: xform_pkg.sv
`default_nettype none

`include "xform_params.svh"

package xform_pkg;

    typedef logic signed [`XFORM_FIX_W-1:0] q16_16_t;
    typedef logic [`XFORM_TAG_W-1:0] xform_tag_t;

    // Per-axis sines and cosines
    typedef struct packed {
        q16_16_t sin_x;
        q16_16_t cos_x;
        q16_16_t sin_y;
        q16_16_t cos_y;
        q16_16_t sin_z;
        q16_16_t cos_z;
    } axis_trig_t;

    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } vec3_t;

    // Row-major 3x3 matrix
    typedef struct packed {
        q16_16_t r11;
        q16_16_t r12;
        q16_16_t r13;
        q16_16_t r21;
        q16_16_t r22;
        q16_16_t r23;
        q16_16_t r31;
        q16_16_t r32;
        q16_16_t r33;
    } rot_mtx_t;

    typedef struct packed {
        xform_tag_t tag;
        axis_trig_t model_trig;
        axis_trig_t camera_trig;
        vec3_t      model_pos;
        q16_16_t    model_scale;
    } xform_setup_t;

    // Payload carried next to the model matrix
    typedef struct packed {
        xform_tag_t tag;
        vec3_t      pos;
        q16_16_t    scale;
    } xform_side_t;

    typedef struct packed {
        xform_tag_t tag;
        rot_mtx_t   mv_mtx;
        vec3_t      model_pos;
        q16_16_t    model_scale;
    } view_xform_t;

    // Full signed product, arithmetic shift, keep low word
    function automatic q16_16_t mul_q16(input q16_16_t a, input q16_16_t b);
        logic signed [2*`XFORM_FIX_W-1:0] prod;
        prod = a * b;
        return q16_16_t'(prod >>> `XFORM_FRAC_BITS);
    endfunction

endpackage

`default_nettype wire
